// ==== include/hci_defs.svh ====
// HCI controller shared widths, queue depths and CSR map
`ifndef HCI_DEFS_SVH
`define HCI_DEFS_SVH

// CSR port
`define HCI_DW 32
`define HCI_AW 12

// Queues
`define HCI_CMD_DEPTH  16
`define HCI_RESP_DEPTH 16
`define HCI_THLD_W     8
`define HCI_DEPTH_W    5

// Register offsets
`define HCI_REG_RESET_CONTROL   12'h000
`define HCI_REG_QUEUE_THLD_CTRL 12'h004
`define HCI_REG_COMMAND_PORT    12'h008
`define HCI_REG_RESPONSE_PORT   12'h00C
`define HCI_REG_QUEUE_STATUS    12'h010
`define HCI_REG_DEVICE_ADDR     12'h014

// Field positions
`define HCI_RST_CMD_QUEUE_BIT   1
`define HCI_RST_RESP_QUEUE_BIT  2
`define HCI_THLD_RESP_LSB       8
`define HCI_STAT_RESP_DEPTH_LSB 8
`define HCI_STAT_CMD_TRIG_BIT   16
`define HCI_STAT_RESP_TRIG_BIT  17
`define HCI_DEV_ADDR_LSB        16
`define HCI_DEV_ADDR_VALID_BIT  31

`endif

// ==== design/hci_csr_pkg.sv ====
// CSR port, queue configuration and dynamic address update types
`include "hci_defs.svh"

package hci_csr_pkg;

  // Software request, one-cycle strobe
  typedef struct packed {
    logic                req;
    logic                is_wr;
    logic [`HCI_AW-1:0]  addr;
    logic [`HCI_DW-1:0]  wdata;
  } csr_req_t;

  // Registered response, valid one cycle after the request
  typedef struct packed {
    logic               rd_ack;
    logic               rd_err;
    logic [`HCI_DW-1:0] rd_data;
    logic               wr_ack;
    logic               wr_err;
  } csr_rsp_t;

  typedef struct packed {
    logic [`HCI_THLD_W-1:0] thld;
    logic                   flush;  // Held until the queue reports done
  } queue_cfg_t;

  // SETDASA / RSTDAA outcome from the controller
  typedef struct packed {
    logic       set_valid;
    logic       rstdaa;  // Wins over set_valid
    logic [6:0] addr;
  } dasa_upd_t;

endpackage

// ==== design/hci_queue_pkg.sv ====
// Command and response descriptor types and queue status
`include "hci_defs.svh"

package hci_queue_pkg;

  // Second COMMAND_PORT dword in the upper half
  typedef struct packed {
    logic [`HCI_DW-1:0] hi;
    logic [`HCI_DW-1:0] lo;
  } cmd_desc_t;

  typedef logic [`HCI_DW-1:0] resp_desc_t;

  typedef struct packed {
    logic [`HCI_DEPTH_W-1:0] depth;
    logic                    full;
    logic                    empty;
    logic                    trig;  // Registered threshold compare
  } queue_stat_t;

endpackage

// ==== design/hci_queue.sv ====
// Descriptor FIFO with flush, depth count and ready-threshold trigger
`timescale 1ns/100ps
`include "hci_defs.svh"

module hci_queue
  import hci_queue_pkg::*;
#(
  parameter int unsigned Depth      = `HCI_CMD_DEPTH,
  parameter type         data_t     = logic [`HCI_DW-1:0],
  parameter bit          TrigOnFree = 1'b0
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  logic                   flush_i,
  output logic                   flush_done_o,
  input  logic [`HCI_THLD_W-1:0] thld_i,
  output queue_stat_t            stat_o,

  input  logic                   wvalid_i,
  output logic                   wready_o,
  input  data_t                  wdata_i,

  output logic                   rvalid_o,
  input  logic                   rready_i,
  output data_t                  rdata_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;

  data_t                   mem_q [Depth];
  logic [PtrW-1:0]         wr_ptr_q;
  logic [PtrW-1:0]         rd_ptr_q;
  logic [`HCI_DEPTH_W-1:0] count_q;
  logic                    full;
  logic                    empty;
  logic                    push;
  logic                    pop;
  logic [`HCI_THLD_W-1:0]  thld_eff;
  logic [`HCI_THLD_W-1:0]  level;
  logic                    trig_q;
  logic                    flush_done_q;

  function automatic logic [PtrW-1:0] next_ptr(logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full  = (count_q == `HCI_DEPTH_W'(Depth));
  assign empty = (count_q == '0);

  // Both sides stall while a flush is pending
  assign wready_o = ~full & ~flush_i;
  assign rvalid_o = ~empty & ~flush_i;
  assign rdata_o  = mem_q[rd_ptr_q];

  assign push = wvalid_i & wready_o;
  assign pop  = rvalid_o & rready_i;

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= wdata_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      count_q <= count_q + `HCI_DEPTH_W'(push) - `HCI_DEPTH_W'(pop);
    end
  end

  // Zero threshold acts as one
  assign thld_eff = (thld_i == '0) ? `HCI_THLD_W'(1) : thld_i;
  assign level    = TrigOnFree ? `HCI_THLD_W'(Depth - count_q) : `HCI_THLD_W'(count_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trig_q       <= 1'b0;
      flush_done_q <= 1'b0;
    end else begin
      trig_q       <= (level >= thld_eff);
      flush_done_q <= flush_i & ~flush_done_q;  // Single pulse per flush
    end
  end

  assign flush_done_o = flush_done_q;

  assign stat_o.depth = count_q;
  assign stat_o.full  = full;
  assign stat_o.empty = empty;
  assign stat_o.trig  = trig_q;

  a_depth_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= Depth);

  // A write offered while full leaves the depth untouched
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    full && wvalid_i && !pop && !flush_i |=> $stable(count_q));

endmodule

// ==== design/cmd_dword_packer.sv ====
// Joins two COMMAND_PORT dwords into one 64-bit command descriptor
`timescale 1ns/100ps
`include "hci_defs.svh"

module cmd_dword_packer
  import hci_queue_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,

  input  logic               word_i,
  input  logic [`HCI_DW-1:0] wdata_i,
  output logic               accepted_o,
  input  logic               flush_i,

  output logic               qvalid_o,
  input  logic               qready_i,
  output cmd_desc_t          qdata_o
);

  logic               phase_q;  // High once the low dword is held
  logic [`HCI_DW-1:0] lo_q;

  // Command goes out together with its second dword
  assign qvalid_o   = word_i & phase_q & ~flush_i;
  assign qdata_o.hi = wdata_i;
  assign qdata_o.lo = lo_q;

  // Second dword refused while the queue is full
  assign accepted_o = word_i & ~flush_i & (~phase_q | qready_i);

  always_ff @(posedge clk_i) begin
    if (word_i && !phase_q) lo_q <= wdata_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= 1'b0;
    end else if (flush_i) begin
      phase_q <= 1'b0;
    end else if (accepted_o) begin
      phase_q <= ~phase_q;
    end
  end

  // A push returns to the first phase, a refused one keeps waiting
  a_push_second_phase: assert property (@(posedge clk_i) disable iff (!rst_ni)
    qvalid_o |-> phase_q ##1 (phase_q ^ $past(qready_i)));

endmodule

// ==== design/hci_csr_regs.sv ====
// HCI register file: address decode, queue ports, reset/threshold control
// and the dynamic address register
`timescale 1ns/100ps
`include "hci_defs.svh"

module hci_csr_regs
  import hci_csr_pkg::*, hci_queue_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,

  input  csr_req_t           csr_req_i,
  output csr_rsp_t           csr_rsp_o,
  input  dasa_upd_t          dasa_i,

  // COMMAND_PORT towards the packer
  output logic               cmd_word_o,
  output logic [`HCI_DW-1:0] cmd_wdata_o,
  input  logic               cmd_accepted_i,

  output queue_cfg_t         cmd_cfg_o,
  output queue_cfg_t         resp_cfg_o,
  input  logic               cmd_flush_done_i,
  input  logic               resp_flush_done_i,
  input  queue_stat_t        cmd_stat_i,
  input  queue_stat_t        resp_stat_i,

  // RESPONSE_PORT pops the response queue
  input  logic               resp_rvalid_i,
  output logic               resp_rready_o,
  input  resp_desc_t         resp_rdata_i
);

  logic                   rd_req;
  logic                   wr_req;
  logic                   sel_rst;
  logic                   sel_thld;
  logic                   sel_cmd;
  logic                   sel_resp;
  logic                   rd_err_d;
  logic                   wr_err_d;
  logic [`HCI_DW-1:0]     rd_data_d;
  logic                   cmd_flush_q;
  logic                   resp_flush_q;
  logic [`HCI_THLD_W-1:0] cmd_thld_q;
  logic [`HCI_THLD_W-1:0] resp_thld_q;
  logic [6:0]             dyn_addr_q;
  logic                   dyn_addr_valid_q;
  csr_rsp_t               rsp_q;

  assign rd_req = csr_req_i.req & ~csr_req_i.is_wr;
  assign wr_req = csr_req_i.req & csr_req_i.is_wr;

  assign sel_rst  = (csr_req_i.addr == `HCI_REG_RESET_CONTROL);
  assign sel_thld = (csr_req_i.addr == `HCI_REG_QUEUE_THLD_CTRL);
  assign sel_cmd  = (csr_req_i.addr == `HCI_REG_COMMAND_PORT);
  assign sel_resp = (csr_req_i.addr == `HCI_REG_RESPONSE_PORT);

  assign cmd_word_o    = wr_req & sel_cmd;
  assign cmd_wdata_o   = csr_req_i.wdata;
  assign resp_rready_o = rd_req & sel_resp;

  always_comb begin
    rd_data_d = '0;
    rd_err_d  = 1'b0;
    wr_err_d  = 1'b0;
    case (csr_req_i.addr)
      `HCI_REG_RESET_CONTROL: begin
        rd_data_d[`HCI_RST_CMD_QUEUE_BIT]  = cmd_flush_q;
        rd_data_d[`HCI_RST_RESP_QUEUE_BIT] = resp_flush_q;
      end
      `HCI_REG_QUEUE_THLD_CTRL: begin
        rd_data_d[`HCI_THLD_W-1:0] = cmd_thld_q;
        rd_data_d[`HCI_THLD_RESP_LSB +: `HCI_THLD_W] = resp_thld_q;
      end
      `HCI_REG_COMMAND_PORT: begin
        wr_err_d = ~cmd_accepted_i;  // Write only, reads as zero
      end
      `HCI_REG_RESPONSE_PORT: begin
        if (resp_rvalid_i) rd_data_d = resp_rdata_i;
        else rd_err_d = 1'b1;  // Nothing to pop
      end
      `HCI_REG_QUEUE_STATUS: begin
        rd_data_d[7:0] = 8'(cmd_stat_i.depth);
        rd_data_d[`HCI_STAT_RESP_DEPTH_LSB +: 8] = 8'(resp_stat_i.depth);
        rd_data_d[`HCI_STAT_CMD_TRIG_BIT]  = cmd_stat_i.trig;
        rd_data_d[`HCI_STAT_RESP_TRIG_BIT] = resp_stat_i.trig;
      end
      `HCI_REG_DEVICE_ADDR: begin
        rd_data_d[`HCI_DEV_ADDR_LSB +: 7]   = dyn_addr_q;
        rd_data_d[`HCI_DEV_ADDR_VALID_BIT] = dyn_addr_valid_q;
      end
      default: begin
        rd_err_d = 1'b1;
        wr_err_d = 1'b1;
      end
    endcase
  end

  // Flush bits self-clear on the queue's done pulse
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_flush_q  <= 1'b0;
      resp_flush_q <= 1'b0;
    end else begin
      cmd_flush_q <= (cmd_flush_q & ~cmd_flush_done_i)
                   | (wr_req & sel_rst & csr_req_i.wdata[`HCI_RST_CMD_QUEUE_BIT]);
      resp_flush_q <= (resp_flush_q & ~resp_flush_done_i)
                    | (wr_req & sel_rst & csr_req_i.wdata[`HCI_RST_RESP_QUEUE_BIT]);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_thld_q  <= `HCI_THLD_W'(1);
      resp_thld_q <= `HCI_THLD_W'(1);
    end else if (wr_req && sel_thld) begin
      cmd_thld_q  <= csr_req_i.wdata[`HCI_THLD_W-1:0];
      resp_thld_q <= csr_req_i.wdata[`HCI_THLD_RESP_LSB +: `HCI_THLD_W];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dyn_addr_q       <= '0;
      dyn_addr_valid_q <= 1'b0;
    end else if (dasa_i.rstdaa) begin
      dyn_addr_q       <= '0;
      dyn_addr_valid_q <= 1'b0;
    end else if (dasa_i.set_valid) begin
      dyn_addr_q       <= dasa_i.addr;
      dyn_addr_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_q <= '0;
    end else begin
      rsp_q.rd_ack  <= rd_req;
      rsp_q.rd_err  <= rd_req & rd_err_d;
      rsp_q.rd_data <= rd_req ? rd_data_d : '0;
      rsp_q.wr_ack  <= wr_req;
      rsp_q.wr_err  <= wr_req & wr_err_d;
    end
  end

  assign csr_rsp_o = rsp_q;

  assign cmd_cfg_o.thld  = cmd_thld_q;
  assign cmd_cfg_o.flush = cmd_flush_q;
  assign resp_cfg_o.thld  = resp_thld_q;
  assign resp_cfg_o.flush = resp_flush_q;

  // One ack, of the matching kind, on the cycle after each request
  a_one_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_req_i.req |=> (csr_rsp_o.rd_ack ^ csr_rsp_o.wr_ack)
                      && (csr_rsp_o.wr_ack == $past(csr_req_i.is_wr)));

  a_no_stray_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !csr_req_i.req |=> !(csr_rsp_o.rd_ack || csr_rsp_o.wr_ack));

endmodule

// ==== design/hci_top.sv ====
// HCI controller top: register file, command packer, command and response queues
`timescale 1ns/100ps
`include "hci_defs.svh"

module hci_top
  import hci_csr_pkg::*, hci_queue_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,

  input  csr_req_t   csr_req_i,
  output csr_rsp_t   csr_rsp_o,
  input  dasa_upd_t  dasa_i,

  // Command queue read side
  output logic       cmd_rvalid_o,
  input  logic       cmd_rready_i,
  output cmd_desc_t  cmd_rdata_o,

  // Response queue write side
  input  logic       resp_wvalid_i,
  output logic       resp_wready_o,
  input  resp_desc_t resp_wdata_i,

  output logic       cmd_thld_trig_o,
  output logic       resp_thld_trig_o
);

  logic               cmd_word;
  logic [`HCI_DW-1:0] cmd_wdata;
  logic               cmd_accepted;
  queue_cfg_t         cmd_cfg;
  queue_cfg_t         resp_cfg;
  logic               cmd_flush_done;
  logic               resp_flush_done;
  queue_stat_t        cmd_stat;
  queue_stat_t        resp_stat;
  logic               pack_valid;
  logic               pack_ready;
  cmd_desc_t          pack_data;
  logic               resp_rvalid;
  logic               resp_rready;
  resp_desc_t         resp_rdata;

  hci_csr_regs i_regs (
    .clk_i,
    .rst_ni,
    .csr_req_i,
    .csr_rsp_o,
    .dasa_i,
    .cmd_word_o        (cmd_word),
    .cmd_wdata_o       (cmd_wdata),
    .cmd_accepted_i    (cmd_accepted),
    .cmd_cfg_o         (cmd_cfg),
    .resp_cfg_o        (resp_cfg),
    .cmd_flush_done_i  (cmd_flush_done),
    .resp_flush_done_i (resp_flush_done),
    .cmd_stat_i        (cmd_stat),
    .resp_stat_i       (resp_stat),
    .resp_rvalid_i     (resp_rvalid),
    .resp_rready_o     (resp_rready),
    .resp_rdata_i      (resp_rdata)
  );

  cmd_dword_packer i_packer (
    .clk_i,
    .rst_ni,
    .word_i     (cmd_word),
    .wdata_i    (cmd_wdata),
    .accepted_o (cmd_accepted),
    .flush_i    (cmd_cfg.flush),
    .qvalid_o   (pack_valid),
    .qready_i   (pack_ready),
    .qdata_o    (pack_data)
  );

  hci_queue #(
    .Depth      (`HCI_CMD_DEPTH),
    .data_t     (cmd_desc_t),
    .TrigOnFree (1'b1)  // Empty-buffer threshold
  ) i_cmd_queue (
    .clk_i,
    .rst_ni,
    .flush_i      (cmd_cfg.flush),
    .flush_done_o (cmd_flush_done),
    .thld_i       (cmd_cfg.thld),
    .stat_o       (cmd_stat),
    .wvalid_i     (pack_valid),
    .wready_o     (pack_ready),
    .wdata_i      (pack_data),
    .rvalid_o     (cmd_rvalid_o),
    .rready_i     (cmd_rready_i),
    .rdata_o      (cmd_rdata_o)
  );

  hci_queue #(
    .Depth      (`HCI_RESP_DEPTH),
    .data_t     (resp_desc_t),
    .TrigOnFree (1'b0)
  ) i_resp_queue (
    .clk_i,
    .rst_ni,
    .flush_i      (resp_cfg.flush),
    .flush_done_o (resp_flush_done),
    .thld_i       (resp_cfg.thld),
    .stat_o       (resp_stat),
    .wvalid_i     (resp_wvalid_i),
    .wready_o     (resp_wready_o),
    .wdata_i      (resp_wdata_i),
    .rvalid_o     (resp_rvalid),
    .rready_i     (resp_rready),
    .rdata_o      (resp_rdata)
  );

  assign cmd_thld_trig_o  = cmd_stat.trig;
  assign resp_thld_trig_o = resp_stat.trig;

endmodule

// ==== verif/hci_tb.sv ====
// HCI controller testbench
// Directed tests over CSR access, both queues, thresholds, flush and address
`timescale 1ns/100ps
`include "hci_defs.svh"

module hci_tb
  import hci_csr_pkg::*, hci_queue_pkg::*;
();

  localparam int NumXfers  = 180;
  localparam int MaxCycles = 20 * NumXfers + 200;

  logic        clk_i;
  logic        rst_ni;
  csr_req_t    csr_req;
  csr_rsp_t    csr_rsp;
  dasa_upd_t   dasa;
  logic        cmd_rvalid;
  logic        cmd_rready;
  cmd_desc_t   cmd_rdata;
  logic        resp_wvalid;
  logic        resp_wready;
  resp_desc_t  resp_wdata;
  logic        cmd_trig;
  logic        resp_trig;

  int          err_cnt = 0;
  int          chk_cnt = 0;
  int          cycle_cnt = 0;
  logic [31:0] rng_state;
  cmd_desc_t   cmd_exp_q[$];
  resp_desc_t  resp_exp_q[$];

  hci_top i_hci_top (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .csr_req_i        (csr_req),
    .csr_rsp_o        (csr_rsp),
    .dasa_i           (dasa),
    .cmd_rvalid_o     (cmd_rvalid),
    .cmd_rready_i     (cmd_rready),
    .cmd_rdata_o      (cmd_rdata),
    .resp_wvalid_i    (resp_wvalid),
    .resp_wready_o    (resp_wready),
    .resp_wdata_i     (resp_wdata),
    .cmd_thld_trig_o  (cmd_trig),
    .resp_thld_trig_o (resp_trig)
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MaxCycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", MaxCycles);
      $display("sim failed");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic check_word(input string name, input logic [`HCI_DW-1:0] got,
                            input logic [`HCI_DW-1:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_cmd(input string name, input cmd_desc_t got, input cmd_desc_t exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input resp_desc_t got, input resp_desc_t exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic csr_access(input logic is_wr, input logic [`HCI_AW-1:0] addr,
                            input logic [`HCI_DW-1:0] wdata,
                            output logic [`HCI_DW-1:0] rdata, output logic err);
    logic ack_ok;
    next_cycle();
    csr_req.req   = 1'b1;
    csr_req.is_wr = is_wr;
    csr_req.addr  = addr;
    csr_req.wdata = wdata;
    next_cycle();
    csr_req = '0;
    ack_ok = is_wr ? (csr_rsp.wr_ack && !csr_rsp.rd_ack) : (csr_rsp.rd_ack && !csr_rsp.wr_ack);
    chk_cnt++;
    if (!ack_ok) begin
      err_cnt++;
      $display("CSR access to %h got no matching ack one cycle after the request", addr);
    end
    rdata = csr_rsp.rd_data;
    err   = is_wr ? csr_rsp.wr_err : csr_rsp.rd_err;
  endtask

  task automatic csr_write(input string name, input logic [`HCI_AW-1:0] addr,
                           input logic [`HCI_DW-1:0] wdata, input logic exp_err);
    logic [`HCI_DW-1:0] rdata;
    logic               err;
    csr_access(1'b1, addr, wdata, rdata, err);
    check_word(name, 32'(err), 32'(exp_err));
  endtask

  task automatic csr_read(input logic [`HCI_AW-1:0] addr, output logic [`HCI_DW-1:0] rdata,
                          output logic err);
    csr_access(1'b0, addr, '0, rdata, err);
  endtask

  task automatic pull_cmd(output cmd_desc_t cmd);
    next_cycle();
    while (!cmd_rvalid) next_cycle();
    cmd = cmd_rdata;
    cmd_rready = 1'b1;
    next_cycle();
    cmd_rready = 1'b0;
  endtask

  task automatic push_resp(input resp_desc_t data);
    next_cycle();
    while (!resp_wready) next_cycle();
    resp_wvalid = 1'b1;
    resp_wdata  = data;
    next_cycle();
    resp_wvalid = 1'b0;
  endtask

  // Low dword goes out first
  task automatic queue_command();
    logic [`HCI_DW-1:0] lo;
    logic [`HCI_DW-1:0] hi;
    lo = next_rand();
    hi = next_rand();
    csr_write("COMMAND_PORT wr_err", `HCI_REG_COMMAND_PORT, lo, 1'b0);
    csr_write("COMMAND_PORT wr_err", `HCI_REG_COMMAND_PORT, hi, 1'b0);
    cmd_exp_q.push_back({hi, lo});
  endtask

  task automatic drain_cmds(input int n);
    cmd_desc_t cmd;
    for (int i = 0; i < n; i++) begin
      pull_cmd(cmd);
      check_cmd("cmd_rdata_o", cmd, cmd_exp_q.pop_front());
    end
  endtask

  task automatic push_resps(input int n);
    resp_desc_t data;
    for (int i = 0; i < n; i++) begin
      data = next_rand();
      push_resp(data);
      resp_exp_q.push_back(data);
    end
  endtask

  task automatic read_resps(input int n);
    logic [`HCI_DW-1:0] rdata;
    logic               err;
    for (int i = 0; i < n; i++) begin
      csr_read(`HCI_REG_RESPONSE_PORT, rdata, err);
      check_word("RESPONSE_PORT rd_err", 32'(err), 32'd0);
      check_resp("RESPONSE_PORT", rdata, resp_exp_q.pop_front());
    end
  endtask

  task automatic test_commands();
    for (int i = 0; i < 8; i++) queue_command();
    drain_cmds(8);
  endtask

  task automatic test_full_queue();
    logic [`HCI_DW-1:0] lo;
    logic [`HCI_DW-1:0] hi;
    logic [`HCI_DW-1:0] rdata;
    logic               err;
    for (int i = 0; i < 16; i++) queue_command();
    lo = next_rand();
    hi = next_rand();
    csr_write("COMMAND_PORT wr_err", `HCI_REG_COMMAND_PORT, lo, 1'b0);
    csr_write("COMMAND_PORT wr_err on full", `HCI_REG_COMMAND_PORT, hi, 1'b1);
    csr_read(`HCI_REG_QUEUE_STATUS, rdata, err);
    check_word("QUEUE_STATUS cmd depth", 32'(rdata[7:0]), 32'd16);
    drain_cmds(16);
    // Packer still waits with the refused command's low dword
    csr_write("COMMAND_PORT wr_err", `HCI_REG_COMMAND_PORT, hi, 1'b0);
    cmd_exp_q.push_back({hi, lo});
    drain_cmds(1);
  endtask

  task automatic test_responses();
    logic [`HCI_DW-1:0] rdata;
    logic               err;
    push_resps(5);
    read_resps(5);
    csr_read(`HCI_REG_RESPONSE_PORT, rdata, err);
    check_word("RESPONSE_PORT rd_err when empty", 32'(err), 32'd1);
    check_word("RESPONSE_PORT data when empty", rdata, 32'd0);
    // Full response queue holds off the controller
    push_resps(`HCI_RESP_DEPTH);
    check_word("resp_wready_o when full", 32'(resp_wready), 32'd0);
    read_resps(`HCI_RESP_DEPTH);
  endtask

  task automatic test_thresholds();
    logic [`HCI_DW-1:0] rdata;
    logic               err;
    csr_write("QUEUE_THLD_CTRL wr_err", `HCI_REG_QUEUE_THLD_CTRL, 32'h0000_030F, 1'b0);
    push_resps(2);
    repeat (2) next_cycle();
    check_word("resp_thld_trig_o", 32'(resp_trig), 32'd0);
    push_resps(1);
    repeat (2) next_cycle();
    check_word("resp_thld_trig_o", 32'(resp_trig), 32'd1);
    queue_command();
    repeat (2) next_cycle();
    check_word("cmd_thld_trig_o", 32'(cmd_trig), 32'd1);
    queue_command();
    repeat (2) next_cycle();
    check_word("cmd_thld_trig_o", 32'(cmd_trig), 32'd0);
    csr_read(`HCI_REG_QUEUE_STATUS, rdata, err);
    check_word("QUEUE_STATUS triggers", 32'(rdata[17:16]), 32'b10);
    // Zero thresholds
    csr_write("QUEUE_THLD_CTRL wr_err", `HCI_REG_QUEUE_THLD_CTRL, 32'h0, 1'b0);
    read_resps(3);
    repeat (14) queue_command();  // No free command entries left
    repeat (2) next_cycle();
    check_word("resp_thld_trig_o at zero threshold", 32'(resp_trig), 32'd0);
    check_word("cmd_thld_trig_o at zero threshold", 32'(cmd_trig), 32'd0);
  endtask

  task automatic test_flush();
    logic [`HCI_DW-1:0] rdata;
    logic               err;
    int                 polls;
    push_resps(2);
    cmd_exp_q.delete();
    resp_exp_q.delete();
    csr_write("RESET_CONTROL wr_err", `HCI_REG_RESET_CONTROL, 32'h0000_0006, 1'b0);
    polls = 0;
    do begin
      csr_read(`HCI_REG_RESET_CONTROL, rdata, err);
      polls++;
    end while (rdata[2:1] != 2'b00 && polls < 4);
    chk_cnt++;
    if (rdata[2:1] != 2'b00) begin
      err_cnt++;
      $display("RESET_CONTROL flush bits were still set after %0d reads", polls);
    end
    csr_read(`HCI_REG_QUEUE_STATUS, rdata, err);
    check_word("QUEUE_STATUS depths", 32'(rdata[15:0]), 32'd0);
    check_word("cmd_rvalid_o", 32'(cmd_rvalid), 32'd0);
    csr_read(12'h040, rdata, err);
    check_word("unmapped rd_err", 32'(err), 32'd1);
    check_word("unmapped rd_data", rdata, 32'd0);
  endtask

  task automatic test_dyn_addr();
    logic [6:0]         addr;
    logic [`HCI_DW-1:0] rdata;
    logic               err;
    addr = 7'(next_rand());
    next_cycle();
    dasa.set_valid = 1'b1;
    dasa.addr      = addr;
    next_cycle();
    dasa = '0;
    csr_read(`HCI_REG_DEVICE_ADDR, rdata, err);
    check_word("DEVICE_ADDR", rdata, {1'b1, 8'h00, addr, 16'h0000});
    // RSTDAA together with SETDASA
    dasa.set_valid = 1'b1;
    dasa.rstdaa    = 1'b1;
    dasa.addr      = 7'(next_rand());
    next_cycle();
    dasa = '0;
    csr_read(`HCI_REG_DEVICE_ADDR, rdata, err);
    check_word("DEVICE_ADDR after RSTDAA", rdata, 32'd0);
  endtask

  initial begin
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    csr_req     = '0;
    dasa        = '0;
    cmd_rready  = 1'b0;
    resp_wvalid = 1'b0;
    resp_wdata  = '0;
    rng_state   = 32'h8a77edea;
    repeat (2) @(posedge clk_i);
    #1;
    check_word("csr_rsp_o flags in reset",
               {28'd0, csr_rsp.rd_ack, csr_rsp.rd_err, csr_rsp.wr_ack, csr_rsp.wr_err}, 32'd0);
    check_word("cmd_rvalid_o in reset", 32'(cmd_rvalid), 32'd0);
    check_word("triggers in reset", {30'd0, cmd_trig, resp_trig}, 32'd0);
    check_word("resp_wready_o in reset", 32'(resp_wready), 32'd1);
    rst_ni = 1'b1;

    test_commands();
    test_full_queue();
    test_responses();
    test_thresholds();
    test_flush();
    test_dyn_addr();

    $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+include
design/hci_csr_pkg.sv
design/hci_queue_pkg.sv
design/hci_queue.sv
design/cmd_dword_packer.sv
design/hci_csr_regs.sv
design/hci_top.sv
verif/hci_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the HCI testbench with Verilator, then look for the pass line in sim.log
rm -f sim.log
verilator --binary --assert --top-module hci_tb -f flist.f -o hci_sim \
  && ./obj_dir/hci_sim | tee sim.log \
  && grep -q "^sim passed$" sim.log \
  || { echo "HCI simulation did not pass"; exit 1; }
